// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tcb_sub_tb -f tcb_sub.f -o tcb_sub_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/tcb_sub_sim > sim.log 2>&1
cat sim.log

grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== src/tcb_map_pkg.sv ====
// TCB memory map and response status
`default_nettype none

package tcb_map_pkg;

  ////////////////////
  // memory window
  ////////////////////

  // first byte of the memory window
  // window size comes from the MEM_AW parameter
  localparam tcb_pkg::tcb_adr_t MEM_BASE = 32'h0000_1000;

  ////////////////////
  // response status
  ////////////////////

  // checked in this order: alignment, then range
  typedef enum logic [1:0] {
    STS_OK    = 2'd0,  // access done
    STS_RANGE = 2'd1,  // outside the window
    STS_ALIGN = 2'd2   // low address bits set
  } tcb_sts_e;

  // any status other than ok reports an error on the bus
  function automatic logic sts_err(input tcb_sts_e sts);
    return (sts != STS_OK);
  endfunction

endpackage

`default_nettype wire

// ==== src/tcb_pkg.sv ====
// TCB bus protocol definitions
`default_nettype none

package tcb_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  // byte address width
  localparam int unsigned TCB_AW = 32;
  // data width
  localparam int unsigned TCB_DW = 32;
  // one enable bit per data byte
  localparam int unsigned TCB_BW = TCB_DW / 8;

  ////////////////////
  // payload types
  ////////////////////

  // byte address
  typedef logic [TCB_AW-1:0] tcb_adr_t;
  // write or read data
  typedef logic [TCB_DW-1:0] tcb_dat_t;
  // byte enables
  typedef logic [TCB_BW-1:0] tcb_ben_t;

  ////////////////////
  // access opcode
  ////////////////////

  // follows the wen encoding on the bus
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } tcb_op_e;

endpackage

`default_nettype wire

// ==== src/tcb_req_hsk.sv ====
// TCB request handshake
`timescale 1ns/1ps
`default_nettype none

module tcb_req_hsk #(
  // wait states before rdy
  parameter int unsigned WAIT = 0
)(
  input  wire                     bus,
  input  wire                     reset,
  // manager request
  input  wire                     vld,
  input  wire                     wen,
  input  wire  tcb_pkg::tcb_adr_t adr,
  input  wire  tcb_pkg::tcb_ben_t ben,
  input  wire  tcb_pkg::tcb_dat_t wdt,
  output logic                    rdy,
  // registered request
  output logic                    req_stb,
  output tcb_pkg::tcb_op_e        req_op,
  output tcb_pkg::tcb_adr_t       req_adr,
  output tcb_pkg::tcb_ben_t       req_ben,
  output tcb_pkg::tcb_dat_t       req_wdt
);

  import tcb_pkg::*;

  // counter holds at most WAIT-1
  localparam int unsigned CW = (WAIT > 1) ? $clog2(WAIT) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_READY
  } state_e;

  state_e        state;
  logic [CW-1:0] cnt;
  logic          trn;

  // transfer when both sides agree
  assign trn = vld & rdy;

  ////////////////////
  // wait state FSM
  ////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      state <= ST_IDLE;
      rdy   <= 1'b0;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (WAIT == 0) begin
            // no stall, rdy up for good
            state <= ST_READY;
            rdy   <= 1'b1;
          end else if (vld) begin
            if (WAIT == 1) begin
              state <= ST_READY;
              rdy   <= 1'b1;
            end else begin
              // remaining wait cycles
              state <= ST_WAIT;
              cnt   <= CW'(WAIT - 1);
            end
          end
        end
        ST_WAIT: begin
          if (cnt == CW'(1)) begin
            state <= ST_READY;
            rdy   <= 1'b1;
          end else begin
            cnt <= cnt - CW'(1);
          end
        end
        ST_READY: begin
          // single rdy cycle when stalling
          if (WAIT != 0) begin
            state <= ST_IDLE;
            rdy   <= 1'b0;
          end
        end
        default: begin
          state <= ST_IDLE;
          rdy   <= 1'b0;
        end
      endcase
    end
  end

  ////////////////////
  // request register
  ////////////////////

  // strobe one cycle after the transfer
  always_ff @(posedge bus) begin
    if (reset) begin
      req_stb <= 1'b0;
    end else begin
      req_stb <= trn;
    end
  end

  // payload captured on transfer
  always_ff @(posedge bus) begin
    if (trn) begin
      req_op  <= wen ? OP_WRITE : OP_READ;
      req_adr <= adr;
      req_ben <= ben;
      req_wdt <= wdt;
    end
  end

endmodule

`default_nettype wire

// ==== src/tcb_rsp_dly.sv ====
// TCB response delay line
`timescale 1ns/1ps
`default_nettype none

module tcb_rsp_dly #(
  // delay stages
  parameter int unsigned DLY = 1
)(
  input  wire                        bus,
  input  wire                        reset,
  // result from memory
  input  wire                        mem_stb,
  input  wire  tcb_pkg::tcb_dat_t    mem_rdt,
  input  wire  tcb_map_pkg::tcb_sts_e mem_sts,
  // bus response
  output logic                       rsp,
  output tcb_pkg::tcb_dat_t          rdt,
  output logic                       err
);

  import tcb_pkg::*;
  import tcb_map_pkg::*;

  // last stage of the line
  logic     stb_o;
  tcb_dat_t rdt_o;
  tcb_sts_e sts_o;

  generate
    if (DLY == 0) begin : g_pass
      // no delay, straight through
      assign stb_o = mem_stb;
      assign rdt_o = mem_rdt;
      assign sts_o = mem_sts;
    end else begin : g_pipe
      logic     stb_q [DLY];
      tcb_dat_t rdt_q [DLY];
      tcb_sts_e sts_q [DLY];

      ////////////////////
      // strobe stages
      ////////////////////

      always_ff @(posedge bus) begin
        if (reset) begin
          for (int i = 0; i < DLY; i++) begin
            stb_q[i] <= 1'b0;
          end
        end else begin
          stb_q[0] <= mem_stb;
          for (int i = 1; i < DLY; i++) begin
            stb_q[i] <= stb_q[i-1];
          end
        end
      end

      // payload shifts along, no reset
      always_ff @(posedge bus) begin
        rdt_q[0] <= mem_rdt;
        sts_q[0] <= mem_sts;
        for (int i = 1; i < DLY; i++) begin
          rdt_q[i] <= rdt_q[i-1];
          sts_q[i] <= sts_q[i-1];
        end
      end

      assign stb_o = stb_q[DLY-1];
      assign rdt_o = rdt_q[DLY-1];
      assign sts_o = sts_q[DLY-1];
    end
  endgenerate

  ////////////////////
  // bus outputs
  ////////////////////

  assign rsp = stb_o;
  // quiet data between responses
  assign rdt = stb_o ? rdt_o : '0;
  // error from status rule
  assign err = stb_o & sts_err(sts_o);

endmodule

`default_nettype wire

// ==== src/tcb_sram.sv ====
// TCB word memory with address check
`timescale 1ns/1ps
`default_nettype none

module tcb_sram #(
  // word address width
  parameter int unsigned MEM_AW = 6
)(
  input  wire                        bus,
  input  wire                        reset,
  // request from handshake side
  input  wire                        req_stb,
  input  wire  tcb_pkg::tcb_op_e     req_op,
  input  wire  tcb_pkg::tcb_adr_t    req_adr,
  input  wire  tcb_pkg::tcb_ben_t    req_ben,
  input  wire  tcb_pkg::tcb_dat_t    req_wdt,
  // result to response side
  output logic                       mem_stb,
  output tcb_pkg::tcb_dat_t          mem_rdt,
  output tcb_map_pkg::tcb_sts_e      mem_sts
);

  import tcb_pkg::*;
  import tcb_map_pkg::*;

  // storage, contents survive reset
  tcb_dat_t mem [0:2**MEM_AW-1];

  tcb_adr_t          adr_off;
  logic [MEM_AW-1:0] idx;
  tcb_sts_e          chk_sts;
  logic              do_wr;
  logic              do_rd;

  ////////////////////
  // address check
  ////////////////////

  // offset into the window, byte units
  assign adr_off = req_adr - MEM_BASE;
  // word index inside the window
  assign idx     = adr_off[MEM_AW+1:2];

  always_comb begin
    if (req_adr[1:0] != 2'b00) begin
      chk_sts = STS_ALIGN;
    end else if ((req_adr < MEM_BASE) || (adr_off[TCB_AW-1:MEM_AW+2] != '0)) begin
      // below base or past the last word
      chk_sts = STS_RANGE;
    end else begin
      chk_sts = STS_OK;
    end
  end

  // only clean accesses touch memory
  assign do_wr = req_stb && (chk_sts == STS_OK) && (req_op == OP_WRITE);
  assign do_rd = (chk_sts == STS_OK) && (req_op == OP_READ);

  ////////////////////
  // memory array
  ////////////////////

  // byte lanes written separately
  always_ff @(posedge bus) begin
    if (do_wr) begin
      for (int i = 0; i < TCB_BW; i++) begin
        if (req_ben[i]) begin
          mem[idx][8*i +: 8] <= req_wdt[8*i +: 8];
        end
      end
    end
  end

  ////////////////////
  // result register
  ////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      mem_stb <= 1'b0;
    end else begin
      mem_stb <= req_stb;
    end
  end

  // full word read, ben ignored
  // writes and errors give zero
  always_ff @(posedge bus) begin
    if (req_stb) begin
      mem_rdt <= do_rd ? mem[idx] : '0;
      mem_sts <= chk_sts;
    end
  end

endmodule

`default_nettype wire

// ==== src/tcb_sub.sv ====
// TCB subordinate top level
`timescale 1ns/1ps
`default_nettype none

module tcb_sub #(
  // response delay stages
  parameter int unsigned DLY    = 2,
  // wait states before rdy
  parameter int unsigned WAIT   = 0,
  // memory holds 2^MEM_AW words
  parameter int unsigned MEM_AW = 6
)(
  input  wire                     bus,
  input  wire                     reset,
  // request
  input  wire                     vld,
  input  wire                     wen,
  input  wire  tcb_pkg::tcb_adr_t adr,
  input  wire  tcb_pkg::tcb_ben_t ben,
  input  wire  tcb_pkg::tcb_dat_t wdt,
  output logic                    rdy,
  // response
  output logic                    rsp,
  output tcb_pkg::tcb_dat_t       rdt,
  output logic                    err
);

  import tcb_pkg::*;
  import tcb_map_pkg::*;

  ////////////////////
  // internal links
  ////////////////////

  // handshake to memory
  logic     req_stb;
  tcb_op_e  req_op;
  tcb_adr_t req_adr;
  tcb_ben_t req_ben;
  tcb_dat_t req_wdt;

  // memory to delay line
  logic     mem_stb;
  tcb_dat_t mem_rdt;
  tcb_sts_e mem_sts;

  // input side, stalls and registers requests
  tcb_req_hsk #(
    .WAIT    (WAIT)
  ) u_req_hsk (
    .bus     (bus),
    .reset   (reset),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rdy     (rdy),
    .req_stb (req_stb),
    .req_op  (req_op),
    .req_adr (req_adr),
    .req_ben (req_ben),
    .req_wdt (req_wdt)
  );

  // processing, checks and accesses storage
  tcb_sram #(
    .MEM_AW  (MEM_AW)
  ) u_sram (
    .bus     (bus),
    .reset   (reset),
    .req_stb (req_stb),
    .req_op  (req_op),
    .req_adr (req_adr),
    .req_ben (req_ben),
    .req_wdt (req_wdt),
    .mem_stb (mem_stb),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts)
  );

  // output side, fixed response latency
  tcb_rsp_dly #(
    .DLY     (DLY)
  ) u_rsp_dly (
    .bus     (bus),
    .reset   (reset),
    .mem_stb (mem_stb),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts),
    .rsp     (rsp),
    .rdt     (rdt),
    .err     (err)
  );

endmodule

`default_nettype wire

// ==== tcb_sub.f ====
src/tcb_pkg.sv
src/tcb_map_pkg.sv
src/tcb_req_hsk.sv
src/tcb_sram.sv
src/tcb_rsp_dly.sv
src/tcb_sub.sv
verif/tcb_sub_tb.sv

// ==== verif/tcb_sub_tb.sv ====
// TCB subordinate testbench
`timescale 1ns/1ps
`default_nettype none

module tcb_sub_tb;

  import tcb_pkg::*;
  import tcb_map_pkg::*;

  localparam int unsigned MEM_AW    = 6;
  localparam int          MEM_WORDS = 2**MEM_AW;
  localparam int unsigned DLY0      = 2;
  localparam int unsigned WAIT0     = 0;
  localparam int unsigned DLY1      = 0;
  localparam int unsigned WAIT1     = 2;
  // requests issued over all tests
  localparam int N_REQ    = 2*MEM_WORDS + 32 + 6 + 4 + 200;
  // worst case cycles per request plus margin
  localparam int WDOG_CYC = N_REQ * (int'(WAIT1) + int'(DLY0) + 6) + 200;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

  logic     bus;
  logic     reset;
  // dut0 ports
  logic     vld0, wen0, rdy0, rsp0, err0;
  tcb_adr_t adr0;
  tcb_ben_t ben0;
  tcb_dat_t wdt0, rdt0;
  // dut1 ports
  logic     vld1, wen1, rdy1, rsp1, err1;
  tcb_adr_t adr1;
  tcb_ben_t ben1;
  tcb_dat_t wdt1, rdt1;

  logic [31:0] lfsr;
  int          cyc;
  int          passes;
  int          fails;
  // stall tracking on dut1
  int          vld1_start;
  logic        vld1_wait;

  // one model memory per dut
  tcb_dat_t model [2][MEM_WORDS];
  // expected responses in request order
  tcb_dat_t q0_rdt[$], q1_rdt[$];
  logic     q0_err[$], q1_err[$];
  int       q0_cyc[$], q1_cyc[$];

  tcb_sub #(.DLY(DLY0), .WAIT(WAIT0), .MEM_AW(MEM_AW)) dut0 (
    .bus(bus), .reset(reset),
    .vld(vld0), .wen(wen0), .adr(adr0), .ben(ben0), .wdt(wdt0), .rdy(rdy0),
    .rsp(rsp0), .rdt(rdt0), .err(err0)
  );

  // stalling instance
  tcb_sub #(.DLY(DLY1), .WAIT(WAIT1), .MEM_AW(MEM_AW)) dut1 (
    .bus(bus), .reset(reset),
    .vld(vld1), .wen(wen1), .adr(adr1), .ben(ben1), .wdt(wdt1), .rdy(rdy1),
    .rsp(rsp1), .rdt(rdt1), .err(err1)
  );

  // 100 ns period
  always #50 bus = ~bus;

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
    end
    return r;
  endfunction

  // expected rdt and err, clean writes go into the model
  function automatic void ref_access(input int d, input logic w, input tcb_adr_t a,
      input tcb_ben_t b, input tcb_dat_t wd, output tcb_dat_t rd, output logic er);
    int idx;
    idx = int'((a - MEM_BASE) >> 2);
    rd  = '0;
    er  = 1'b1;
    // aligned and inside the window
    if (a[1:0] == 2'b00 && a >= MEM_BASE && a < MEM_BASE + tcb_adr_t'(4 * MEM_WORDS)) begin
      er = 1'b0;
      if (w) begin
        for (int i = 0; i < TCB_BW; i++) begin
          if (b[i]) begin
            model[d][idx][8*i +: 8] = wd[8*i +: 8];
          end
        end
      end else begin
        rd = model[d][idx];
      end
    end
  endfunction

  task automatic check_rdt(input tcb_dat_t got, input tcb_dat_t exp, input string what);
    if (got === exp) begin
      passes++;
    end else begin
      fails++;
      $display("Fail @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got === exp) begin
      passes++;
    end else begin
      fails++;
      $display("Fail @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // level of a handshake signal
  task automatic check_lvl(input logic got, input logic exp, input string what);
    if (got === exp) begin
      passes++;
    end else begin
      fails++;
      $display("Fail @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // cycles between two events
  task automatic check_lat(input int got, input int exp, input string what);
    if (got == exp) begin
      passes++;
    end else begin
      fails++;
      $display("Fail @%0t: %s got %0d cycles expected %0d", $time, what, got, exp);
    end
  endtask

  // drives one request and returns in the cycle it is taken
  task automatic send(input int d, input logic w, input tcb_adr_t a, input tcb_ben_t b,
      input tcb_dat_t wd);
    @(negedge bus);
    if (d == 0) begin
      vld0 = 1'b1;
      wen0 = w;
      adr0 = a;
      ben0 = b;
      wdt0 = wd;
      while (!rdy0) @(negedge bus);
    end else begin
      vld1 = 1'b1;
      wen1 = w;
      adr1 = a;
      ben1 = b;
      wdt1 = wd;
      while (!rdy1) @(negedge bus);
    end
  endtask

  // drops vld and waits for every response
  task automatic drain();
    @(negedge bus);
    vld0 = 1'b0;
    vld1 = 1'b0;
    while (q0_rdt.size() != 0 || q1_rdt.size() != 0) @(posedge bus);
  endtask

  task automatic report_test(input int n, input string name, input int f0);
    $display("test %0d %s finished with %0d failed checks", n, name, fails - f0);
  endtask

  ////////////////////
  // transfer monitor
  ////////////////////

  // inputs settled since the falling edge
  always @(posedge bus) begin
    tcb_dat_t rd;
    logic     er;
    if (reset) begin
      vld1_wait = 1'b0;
    end else begin
      if (vld0 && rdy0) begin
        ref_access(0, wen0, adr0, ben0, wdt0, rd, er);
        q0_rdt.push_back(rd);
        q0_err.push_back(er);
        q0_cyc.push_back(cyc);
      end
      // first cycle of a new vld on dut1
      if (vld1 && !vld1_wait) begin
        vld1_wait  = 1'b1;
        vld1_start = cyc;
      end
      if (vld1 && rdy1) begin
        check_lat(cyc - vld1_start, int'(WAIT1), "dut1 stall");
        vld1_wait = 1'b0;
        ref_access(1, wen1, adr1, ben1, wdt1, rd, er);
        q1_rdt.push_back(rd);
        q1_err.push_back(er);
        q1_cyc.push_back(cyc);
      end
    end
    cyc++;
  end

  ////////////////////
  // response compare
  ////////////////////

  always @(negedge bus) begin
    if (!reset) begin
      if (rsp0) begin
        if (q0_rdt.size() == 0) begin
          fails++;
          $display("dut0 gave a response with no request pending at %0t", $time);
        end else begin
          check_rdt(rdt0, q0_rdt.pop_front(), "dut0 rdt");
          check_err(err0, q0_err.pop_front(), "dut0 err");
          check_lat(cyc - q0_cyc.pop_front(), int'(DLY0) + 2, "dut0 latency");
        end
      end
      if (rsp1) begin
        if (q1_rdt.size() == 0) begin
          fails++;
          $display("dut1 gave a response with no request pending at %0t", $time);
        end else begin
          check_rdt(rdt1, q1_rdt.pop_front(), "dut1 rdt");
          check_err(err1, q1_err.pop_front(), "dut1 err");
          check_lat(cyc - q1_cyc.pop_front(), int'(DLY1) + 2, "dut1 latency");
        end
      end
    end
  end

  // ends a hung run
  initial begin : watchdog
    #(WDOG_CYC * 100);
    $display("timeout: responses still missing after %0d cycles", WDOG_CYC);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////
  // tests
  ////////////////////

  initial begin : main
    tcb_adr_t    a;
    tcb_dat_t    wd;
    logic [31:0] r;
    logic [31:0] b;
    int          f0;
    bus    = 1'b0;
    reset  = 1'b1;
    {vld0, wen0, adr0, ben0, wdt0} = '0;
    {vld1, wen1, adr1, ben1, wdt1} = '0;
    lfsr   = 32'he07f;
    cyc    = 0;
    passes = 0;
    fails  = 0;
    repeat (5) @(negedge bus);
    reset = 1'b0;

    // test 1 looks at the idle state after reset
    f0 = fails;
    @(negedge bus);
    check_lvl(rdy0, 1'b1, "dut0 rdy after reset");
    check_lvl(rsp0, 1'b0, "dut0 rsp after reset");
    check_lvl(rsp1, 1'b0, "dut1 rsp after reset");
    repeat (3) begin
      check_lvl(rdy1, 1'b0, "dut1 rdy without vld");
      @(negedge bus);
    end
    report_test(1, "reset", f0);

    // test 2 writes every word then reads it back
    f0 = fails;
    for (int i = 0; i < MEM_WORDS; i++) begin
      send(0, 1'b1, MEM_BASE + tcb_adr_t'(4 * i), 4'hf, rand_bits(32));
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      send(0, 1'b0, MEM_BASE + tcb_adr_t'(4 * i), 4'h0, '0);
    end
    drain();
    report_test(2, "full word write and read", f0);

    // test 3 merges byte lanes
    f0 = fails;
    for (int i = 0; i < 16; i++) begin
      b  = rand_bits(4);
      wd = rand_bits(32);
      send(0, 1'b1, MEM_BASE + tcb_adr_t'(8 * i), tcb_ben_t'(b), wd);
    end
    for (int i = 0; i < 16; i++) begin
      send(0, 1'b0, MEM_BASE + tcb_adr_t'(8 * i), 4'hf, '0);
    end
    drain();
    report_test(3, "partial write", f0);

    // test 4 sends range and alignment errors
    // a write below the base would wrap onto the last word
    // misaligned writes would land on word 0
    f0 = fails;
    send(0, 1'b1, MEM_BASE - 32'd4, 4'hf, 32'hdead_beef);
    send(0, 1'b0, MEM_BASE + tcb_adr_t'(4 * MEM_WORDS), 4'hf, '0);
    send(0, 1'b1, MEM_BASE + 32'd2, 4'hf, 32'h1234_5678);
    send(0, 1'b0, MEM_BASE + 32'd1, 4'hf, '0);
    send(0, 1'b0, MEM_BASE, 4'hf, '0);
    send(0, 1'b0, MEM_BASE + tcb_adr_t'(4 * (MEM_WORDS - 1)), 4'hf, '0);
    drain();
    report_test(4, "address errors", f0);

    // test 5 holds vld across requests while dut1 stalls
    f0 = fails;
    send(1, 1'b1, MEM_BASE + 32'd12, 4'hf, rand_bits(32));
    send(1, 1'b1, MEM_BASE + 32'd20, 4'hf, rand_bits(32));
    send(1, 1'b0, MEM_BASE + 32'd12, 4'hf, '0);
    send(1, 1'b0, MEM_BASE + 32'd20, 4'hf, '0);
    drain();
    report_test(5, "wait states", f0);

    // test 6 runs back to back random traffic
    f0 = fails;
    for (int i = 0; i < 200; i++) begin
      r = rand_bits(6);
      a = MEM_BASE + tcb_adr_t'({r[5:0], 2'b00});
      // about one in sixteen is a bad address
      if (rand_bits(4) == 32'd0) begin
        a = a + ((rand_bits(1) == 32'd1) ? 32'h100 : 32'h2);
      end
      r  = rand_bits(1);
      b  = rand_bits(4);
      wd = rand_bits(32);
      send(0, r[0], a, tcb_ben_t'(b), wd);
    end
    drain();
    report_test(6, "random traffic", f0);

    $display("checks passed %0d failed %0d", passes, fails);
    if (fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
